// ==== src/mem_sp.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sp (
  input  wire logic              clk,
  input  wire logic              we,
  input  wire ninjin_pkg::idx_t  addr,
  input  wire ninjin_pkg::beat_t wdata,
  output ninjin_pkg::beat_t      rdata
);

  ninjin_pkg::beat_t mem [ninjin_pkg::BURST_LEN];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== src/ninjin_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_ctrl (
  input  wire logic              clk,
  input  wire logic              xrst,
  input  wire logic              prefetch,
  input  wire ninjin_pkg::addr_t base_addr,
  input  wire ninjin_pkg::len_t  total_len,
  input  wire logic              mem_we,
  input  wire ninjin_pkg::addr_t mem_addr,
  input  wire logic              beat_wr,
  input  wire logic              pref_last,
  output ninjin_pkg::state_t     state,
  output ninjin_pkg::addr_t      cmd_base,
  output ninjin_pkg::len_t       cmd_len,
  output ninjin_pkg::len_t       words_left,
  output logic                   last_word,
  output logic                   fill_sel,
  output logic                   pref_start,
  output logic                   burst_done,
  output logic                   tail_done
);

  logic             pref_go;
  logic             wr_go;
  logic             pref_pend;
  logic             stream_end;
  logic             burst_end;
  ninjin_pkg::len_t word_cnt;
  ninjin_pkg::idx_t beat_cnt;

  assign pref_go = state == ninjin_pkg::S_IDLE && prefetch;
  assign wr_go   = state == ninjin_pkg::S_IDLE && !prefetch && mem_we;

  // final word of the stream, first word included
  always_comb begin
    if (wr_go) begin
      last_word = total_len <= ninjin_pkg::len_t'(1);
    end else begin
      last_word = state == ninjin_pkg::S_WRITE && mem_we
               && word_cnt + ninjin_pkg::len_t'(1) == cmd_len;
    end
  end

  // stored beat closes a burst or the stream
  assign burst_end = beat_wr
                  && (stream_end || beat_cnt == ninjin_pkg::idx_t'(ninjin_pkg::BURST_LEN - 1));

  // ====================
  // state machine
  // ====================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= ninjin_pkg::S_IDLE;
    end else begin
      case (state)
        ninjin_pkg::S_IDLE: begin
          if (pref_go) begin
            state <= ninjin_pkg::S_PREF;
          end else if (wr_go) begin
            state <= ninjin_pkg::S_WRITE;
          end
        end
        ninjin_pkg::S_PREF: begin
          if (pref_last) begin
            state <= ninjin_pkg::S_IDLE;
          end
        end
        // back to idle with the tail request
        ninjin_pkg::S_WRITE: begin
          if (tail_done) begin
            state <= ninjin_pkg::S_IDLE;
          end
        end
        default: begin
          state <= ninjin_pkg::S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      cmd_base <= '0;
      cmd_len  <= '0;
    end else if (pref_go) begin
      cmd_base <= base_addr;
      cmd_len  <= total_len;
    end else if (wr_go) begin
      cmd_base <= mem_addr;
      cmd_len  <= total_len;
    end
  end

  // ====================
  // pulses and counters
  // ====================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      pref_pend  <= 1'b0;
      pref_start <= 1'b0;
      burst_done <= 1'b0;
      tail_done  <= 1'b0;
      fill_sel   <= 1'b0;
    end else begin
      pref_pend  <= pref_go;
      pref_start <= pref_pend;
      burst_done <= burst_end && !stream_end;
      tail_done  <= burst_end && stream_end;
      if (burst_end) begin
        fill_sel <= !fill_sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      word_cnt   <= '0;
      beat_cnt   <= '0;
      words_left <= '0;
    end else if (wr_go) begin
      word_cnt   <= ninjin_pkg::len_t'(1);
      beat_cnt   <= '0;
      words_left <= total_len;
    end else begin
      if (state == ninjin_pkg::S_WRITE && mem_we) begin
        word_cnt <= word_cnt + 1'b1;
      end
      if (beat_wr) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      if (burst_end && !stream_end) begin
        words_left <= words_left - ninjin_pkg::len_t'(ninjin_pkg::BURST_WORDS);
      end
    end
  end

  // waits for the beat holding the last word
  always_ff @(posedge clk) begin
    if (!xrst) begin
      stream_end <= 1'b0;
    end else if (last_word) begin
      stream_end <= 1'b1;
    end else if (burst_end) begin
      stream_end <= 1'b0;
    end
  end

  a_wr_consec: assert property (
    @(posedge clk) disable iff (!xrst)
    state == ninjin_pkg::S_WRITE && mem_we
      |-> mem_addr == cmd_base + ninjin_pkg::addr_t'(word_cnt)
  ) else $error("write stream address is not consecutive");

  a_pref_idle: assert property (
    @(posedge clk) disable iff (!xrst)
    prefetch |-> state == ninjin_pkg::S_IDLE
  ) else $error("prefetch outside idle");

endmodule

`default_nettype wire

// ==== src/ninjin_ddr_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_ddr_buf (
  input  wire logic              clk,
  input  wire logic              xrst,
  input  wire logic              prefetch,
  input  wire ninjin_pkg::addr_t base_addr,
  input  wire ninjin_pkg::len_t  total_len,
  input  wire logic              mem_we,
  input  wire ninjin_pkg::addr_t mem_addr,
  input  wire ninjin_pkg::word_t mem_wdata,
  input  wire logic              ddr_we,
  input  wire ninjin_pkg::idx_t  ddr_addr,
  input  wire ninjin_pkg::beat_t ddr_wdata,
  output logic                   ddr_req,
  output logic                   ddr_mode,
  output ninjin_pkg::addr_t      ddr_base,
  output ninjin_pkg::len_t       ddr_len,
  output ninjin_pkg::beat_t      ddr_rdata,
  output ninjin_pkg::word_t      mem_rdata
);

  ninjin_pkg::state_t state;
  ninjin_pkg::addr_t  cmd_base;
  ninjin_pkg::len_t   cmd_len;
  ninjin_pkg::len_t   words_left;
  logic               last_word;
  logic               fill_sel;
  logic               pref_start;
  logic               burst_done;
  logic               tail_done;
  logic               beat_wr;
  logic               pref_last;

  ninjin_ctrl u_ctrl (
    .clk        (clk),
    .xrst       (xrst),
    .prefetch   (prefetch),
    .base_addr  (base_addr),
    .total_len  (total_len),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .beat_wr    (beat_wr),
    .pref_last  (pref_last),
    .state      (state),
    .cmd_base   (cmd_base),
    .cmd_len    (cmd_len),
    .words_left (words_left),
    .last_word  (last_word),
    .fill_sel   (fill_sel),
    .pref_start (pref_start),
    .burst_done (burst_done),
    .tail_done  (tail_done)
  );

  ninjin_ddr_cmd u_ddr_cmd (
    .clk        (clk),
    .xrst       (xrst),
    .state      (state),
    .cmd_base   (cmd_base),
    .cmd_len    (cmd_len),
    .words_left (words_left),
    .pref_start (pref_start),
    .burst_done (burst_done),
    .tail_done  (tail_done),
    .ddr_req    (ddr_req),
    .ddr_mode   (ddr_mode),
    .ddr_base   (ddr_base),
    .ddr_len    (ddr_len)
  );

  // boot buffer for the first burst
  ninjin_prefetch u_prefetch (
    .clk       (clk),
    .state     (state),
    .cmd_base  (cmd_base),
    .cmd_len   (cmd_len),
    .mem_addr  (mem_addr),
    .ddr_we    (ddr_we),
    .ddr_addr  (ddr_addr),
    .ddr_wdata (ddr_wdata),
    .pref_last (pref_last),
    .mem_rdata (mem_rdata)
  );

  // write side double buffer
  ninjin_pingpong u_pingpong (
    .clk       (clk),
    .xrst      (xrst),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata),
    .last_word (last_word),
    .fill_sel  (fill_sel),
    .ddr_addr  (ddr_addr),
    .beat_wr   (beat_wr),
    .ddr_rdata (ddr_rdata)
  );

endmodule

`default_nettype wire

// ==== src/ninjin_ddr_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_ddr_cmd (
  input  wire logic               clk,
  input  wire logic               xrst,
  input  wire ninjin_pkg::state_t state,
  input  wire ninjin_pkg::addr_t  cmd_base,
  input  wire ninjin_pkg::len_t   cmd_len,
  input  wire ninjin_pkg::len_t   words_left,
  input  wire logic               pref_start,
  input  wire logic               burst_done,
  input  wire logic               tail_done,
  output logic                    ddr_req,
  output logic                    ddr_mode,
  output ninjin_pkg::addr_t       ddr_base,
  output ninjin_pkg::len_t        ddr_len
);

  ninjin_pkg::addr_t burst_off;
  ninjin_pkg::len_t  req_len;

  // prefetch capped at one burst, tail rounded up to whole beats
  assign req_len = ninjin_pkg::ceil_beats(pref_start ? cmd_len : words_left);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ddr_req   <= 1'b0;
      ddr_mode  <= 1'b0;
      ddr_base  <= '0;
      ddr_len   <= '0;
      burst_off <= '0;
    end else begin
      ddr_req <= pref_start || burst_done || tail_done;
      if (pref_start) begin
        ddr_mode <= ninjin_pkg::DDR_READ;
        ddr_base <= cmd_base;
        ddr_len  <= req_len;
      end else if (burst_done || tail_done) begin
        ddr_mode  <= ninjin_pkg::DDR_WRITE;
        ddr_base  <= cmd_base + burst_off;
        burst_off <= burst_off + ninjin_pkg::addr_t'(ninjin_pkg::BURST_WORDS);
        if (burst_done) begin
          ddr_len <= ninjin_pkg::len_t'(ninjin_pkg::BURST_LEN);
        end else begin
          ddr_len <= req_len;
        end
      end else if (state == ninjin_pkg::S_IDLE) begin
        ddr_mode  <= 1'b0;
        ddr_base  <= '0;
        ddr_len   <= '0;
        burst_off <= '0;
      end
    end
  end

  // requests come from distinct controller events
  a_req_pulse: assert property (
    @(posedge clk) disable iff (!xrst)
    ddr_req |=> !ddr_req
  ) else $error("ddr_req held for two cycles");

endmodule

`default_nettype wire

// ==== src/ninjin_pingpong.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_pingpong (
  input  wire logic              clk,
  input  wire logic              xrst,
  input  wire logic              mem_we,
  input  wire ninjin_pkg::word_t mem_wdata,
  input  wire logic              last_word,
  input  wire logic              fill_sel,
  input  wire ninjin_pkg::idx_t  ddr_addr,
  output logic                   beat_wr,
  output ninjin_pkg::beat_t      ddr_rdata
);

  localparam int W  = ninjin_pkg::DWIDTH;
  localparam int BW = ninjin_pkg::BWIDTH;

  ninjin_pkg::beat_t              pack_q;
  ninjin_pkg::beat_t              pack_next;
  ninjin_pkg::beat_t              beat_q;
  logic [ninjin_pkg::RATELOG-1:0] wcnt;
  logic                           beat_close;
  logic                           flip;
  logic                           fill_q;
  logic                           drain_sel;
  ninjin_pkg::idx_t               fill_idx;
  ninjin_pkg::len_t               drain_cnt [2];
  ninjin_pkg::beat_t              buf_rdata [2];

  // ====================
  // word packer
  // ====================

  // new word enters at the top, word 0 ends in the low bits
  assign pack_next  = {mem_wdata, pack_q[BW-1:W]};
  assign beat_close = mem_we && (wcnt == ninjin_pkg::RATE - 1 || last_word);

  always_ff @(posedge clk) begin
    if (mem_we) begin
      pack_q <= pack_next;
    end
    // short beat slides down, upper words zero
    if (beat_close) begin
      beat_q <= pack_next >> (W * (ninjin_pkg::RATE - 1 - int'(wcnt)));
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wcnt    <= '0;
      beat_wr <= 1'b0;
    end else begin
      beat_wr <= beat_close;
      if (beat_close) begin
        wcnt <= '0;
      end else if (mem_we) begin
        wcnt <= wcnt + 1'b1;
      end
    end
  end

  // ====================
  // buffer pointers
  // ====================

  assign flip = fill_sel != fill_q;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      fill_q    <= 1'b0;
      drain_sel <= 1'b1;
      fill_idx  <= '0;
    end else begin
      fill_q    <= fill_sel;
      drain_sel <= !fill_sel;
      if (flip) begin
        fill_idx <= '0;
      end else if (beat_wr) begin
        fill_idx <= fill_idx + 1'b1;
      end
    end
  end

  // drain window per buffer after it is handed over
  always_ff @(posedge clk) begin
    if (!xrst) begin
      drain_cnt[0] <= '0;
      drain_cnt[1] <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (flip && fill_q == 1'(i)) begin
          drain_cnt[i] <= ninjin_pkg::len_t'(ninjin_pkg::BURST_WORDS + 1);
        end else if (drain_cnt[i] != '0) begin
          drain_cnt[i] <= drain_cnt[i] - 1'b1;
        end
      end
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_buf
    logic is_fill;

    assign is_fill = fill_sel == 1'(i);

    mem_sp u_mem (
      .clk   (clk),
      .we    (beat_wr && is_fill),
      .addr  (is_fill ? fill_idx : ddr_addr),
      .wdata (beat_q),
      .rdata (buf_rdata[i])
    );
  end

  assign ddr_rdata = buf_rdata[drain_sel];

  a_no_overrun: assert property (
    @(posedge clk) disable iff (!xrst)
    beat_wr |-> drain_cnt[fill_sel] == '0
  ) else $error("fill into a buffer still draining");

endmodule

`default_nettype wire

// ==== src/ninjin_pkg.sv ====
`default_nettype none

package ninjin_pkg;

  localparam int DWIDTH      = 16;
  localparam int RATE        = 2;
  localparam int BWIDTH      = DWIDTH * RATE;
  localparam int RATELOG     = $clog2(RATE);
  localparam int BURST_LEN   = 8;
  localparam int BURST_WORDS = RATE * BURST_LEN;
  localparam int BUFSIZE     = 3;
  localparam int IMGSIZE     = 16;
  localparam int LWIDTH      = 16;

  // ddr_mode codes
  localparam logic DDR_READ  = 1'b0;
  localparam logic DDR_WRITE = 1'b1;

  typedef logic signed [DWIDTH-1:0] word_t;
  typedef logic [BWIDTH-1:0]        beat_t;
  typedef logic [IMGSIZE-1:0]       addr_t;
  typedef logic [LWIDTH-1:0]        len_t;
  typedef logic [BUFSIZE-1:0]       idx_t;

  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,
    S_PREF  = 2'd1,
    S_WRITE = 2'd2
  } state_t;

  // beats needed for up to one burst of words, rounded up
  function automatic len_t ceil_beats(len_t words);
    len_t n;
    n = (words < len_t'(BURST_WORDS)) ? words : len_t'(BURST_WORDS);
    return (n + len_t'(RATE - 1)) >> RATELOG;
  endfunction

endpackage

`default_nettype wire

// ==== src/ninjin_prefetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_prefetch (
  input  wire logic               clk,
  input  wire ninjin_pkg::state_t state,
  input  wire ninjin_pkg::addr_t  cmd_base,
  input  wire ninjin_pkg::len_t   cmd_len,
  input  wire ninjin_pkg::addr_t  mem_addr,
  input  wire logic               ddr_we,
  input  wire ninjin_pkg::idx_t   ddr_addr,
  input  wire ninjin_pkg::beat_t  ddr_wdata,
  output logic                    pref_last,
  output ninjin_pkg::word_t       mem_rdata
);

  localparam int OFS_TOP = ninjin_pkg::BUFSIZE + ninjin_pkg::RATELOG - 1;

  logic                           in_pref;
  logic                           boot_we;
  ninjin_pkg::idx_t               boot_addr;
  ninjin_pkg::idx_t               last_idx;
  ninjin_pkg::addr_t              offset;
  ninjin_pkg::beat_t              boot_rdata;
  logic [ninjin_pkg::RATELOG-1:0] word_off;

  assign in_pref  = state == ninjin_pkg::S_PREF;
  assign last_idx = ninjin_pkg::idx_t'(ninjin_pkg::ceil_beats(cmd_len) - 1);

  // the beat that completes the prefetch
  assign pref_last = in_pref && ddr_we && ddr_addr == last_idx;

  // word offset into the prefetched image
  assign offset = mem_addr - cmd_base;

  assign boot_we   = in_pref && ddr_we;
  assign boot_addr = in_pref ? ddr_addr : offset[OFS_TOP:ninjin_pkg::RATELOG];

  always_ff @(posedge clk) begin
    word_off <= offset[ninjin_pkg::RATELOG-1:0];
  end

  mem_sp u_boot (
    .clk   (clk),
    .we    (boot_we),
    .addr  (boot_addr),
    .wdata (ddr_wdata),
    .rdata (boot_rdata)
  );

  // pick the word out of the beat read last cycle
  assign mem_rdata = boot_rdata[word_off*ninjin_pkg::DWIDTH +: ninjin_pkg::DWIDTH];

endmodule

`default_nettype wire

// ==== test/ninjin_ddr_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_ddr_model #(
  parameter logic [31:0] SEED = 32'd1
) (
  input  wire logic              clk,
  input  wire logic              ddr_req,
  input  wire logic              ddr_mode,
  input  wire ninjin_pkg::addr_t ddr_base,
  input  wire ninjin_pkg::len_t  ddr_len,
  input  wire ninjin_pkg::beat_t ddr_rdata,
  output logic                   ddr_we,
  output ninjin_pkg::idx_t       ddr_addr,
  output ninjin_pkg::beat_t      ddr_wdata,
  output logic                   busy,
  output logic                   rec_valid,
  output ninjin_pkg::addr_t      rec_base,
  output ninjin_pkg::idx_t       rec_idx,
  output ninjin_pkg::beat_t      rec_beat
);

  // image word at a word address, one lcg step
  function automatic ninjin_pkg::word_t image_word(ninjin_pkg::addr_t a);
    logic [31:0] s;
    s = SEED ^ {a, a};
    s = s * 32'd1103515245 + 32'd12345;
    return ninjin_pkg::word_t'(s[31:16]);
  endfunction

  // beats land two cycles after the request
  task automatic serve_read(input ninjin_pkg::addr_t base, input int len);
    int                i;
    int                j;
    ninjin_pkg::beat_t b;
    @(negedge clk);
    for (i = 0; i < len; i++) begin
      for (j = 0; j < ninjin_pkg::RATE; j++) begin
        b[j*ninjin_pkg::DWIDTH +: ninjin_pkg::DWIDTH] =
          image_word(base + ninjin_pkg::addr_t'(i * ninjin_pkg::RATE + j));
      end
      ddr_we    = 1'b1;
      ddr_addr  = ninjin_pkg::idx_t'(i);
      ddr_wdata = b;
      @(negedge clk);
    end
    ddr_we = 1'b0;
  endtask

  // ddr_rdata follows ddr_addr by one cycle
  task automatic serve_write(input ninjin_pkg::addr_t base, input int len);
    int i;
    for (i = 0; i < len; i++) begin
      ddr_addr = ninjin_pkg::idx_t'(i);
      @(negedge clk);
      rec_valid = 1'b1;
      rec_base  = base;
      rec_idx   = ninjin_pkg::idx_t'(i);
      rec_beat  = ddr_rdata;
    end
  endtask

  initial begin
    ddr_we    = 1'b0;
    ddr_addr  = '0;
    ddr_wdata = '0;
    busy      = 1'b0;
    rec_valid = 1'b0;
    rec_base  = '0;
    rec_idx   = '0;
    rec_beat  = '0;
    forever begin
      @(negedge clk);
      rec_valid = 1'b0;
      if (ddr_req) begin
        busy = 1'b1;
        if (ddr_mode == ninjin_pkg::DDR_READ) begin
          serve_read(ddr_base, int'(ddr_len));
        end else begin
          serve_write(ddr_base, int'(ddr_len));
        end
        busy = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_ninjin.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ninjin;

  logic              clk = 1'b0;
  logic              xrst;
  logic              prefetch;
  ninjin_pkg::addr_t base_addr;
  ninjin_pkg::len_t  total_len;
  logic              mem_we;
  ninjin_pkg::addr_t mem_addr;
  ninjin_pkg::word_t mem_wdata;
  logic              ddr_we;
  ninjin_pkg::idx_t  ddr_addr;
  ninjin_pkg::beat_t ddr_wdata;
  logic              ddr_req;
  logic              ddr_mode;
  ninjin_pkg::addr_t ddr_base;
  ninjin_pkg::len_t  ddr_len;
  ninjin_pkg::beat_t ddr_rdata;
  ninjin_pkg::word_t mem_rdata;
  logic              ddr_busy;
  logic              rec_valid;
  ninjin_pkg::addr_t rec_base;
  ninjin_pkg::idx_t  rec_idx;
  ninjin_pkg::beat_t rec_beat;

  int          cyc = 0;
  int          beats_seen = 0;
  int          req_errors = 0;
  int          data_errors = 0;
  int          read_errors = 0;
  logic [31:0] seed = 32'd56412;

  // stream being drained
  ninjin_pkg::word_t stream_q [$];
  ninjin_pkg::addr_t str_base;
  int                str_len;

  // beats the model wrote during prefetch
  ninjin_pkg::beat_t boot_img [ninjin_pkg::BURST_LEN];

  int                exp_cyc  [$];
  logic              exp_mode [$];
  ninjin_pkg::addr_t exp_base [$];
  ninjin_pkg::len_t  exp_len  [$];

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  ninjin_ddr_buf dut (
    .clk       (clk),
    .xrst      (xrst),
    .prefetch  (prefetch),
    .base_addr (base_addr),
    .total_len (total_len),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .ddr_we    (ddr_we),
    .ddr_addr  (ddr_addr),
    .ddr_wdata (ddr_wdata),
    .ddr_req   (ddr_req),
    .ddr_mode  (ddr_mode),
    .ddr_base  (ddr_base),
    .ddr_len   (ddr_len),
    .ddr_rdata (ddr_rdata),
    .mem_rdata (mem_rdata)
  );

  ninjin_ddr_model #(.SEED(32'd56412)) u_ddr (
    .clk       (clk),
    .ddr_req   (ddr_req),
    .ddr_mode  (ddr_mode),
    .ddr_base  (ddr_base),
    .ddr_len   (ddr_len),
    .ddr_rdata (ddr_rdata),
    .ddr_we    (ddr_we),
    .ddr_addr  (ddr_addr),
    .ddr_wdata (ddr_wdata),
    .busy      (ddr_busy),
    .rec_valid (rec_valid),
    .rec_base  (rec_base),
    .rec_idx   (rec_idx),
    .rec_beat  (rec_beat)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // up to one burst of words, rounded up to beats
  function automatic int beats_for(int words);
    int w;
    w = (words < ninjin_pkg::BURST_WORDS) ? words : ninjin_pkg::BURST_WORDS;
    return (w + ninjin_pkg::RATE - 1) / ninjin_pkg::RATE;
  endfunction

  // word 0 in the low bits, words past the stream end are zero
  function automatic ninjin_pkg::beat_t expected_beat(ninjin_pkg::addr_t base,
                                                      ninjin_pkg::idx_t idx);
    ninjin_pkg::beat_t b;
    int                j;
    int                k;
    b = '0;
    for (j = 0; j < ninjin_pkg::RATE; j++) begin
      k = int'(ninjin_pkg::addr_t'(base - str_base)) + int'(idx) * ninjin_pkg::RATE + j;
      if (k < str_len) begin
        b[j*ninjin_pkg::DWIDTH +: ninjin_pkg::DWIDTH] = stream_q[k];
      end
    end
    return b;
  endfunction

  // ====================
  // request checks
  // ====================

  // called on the drive edge, request due 2 cycles after the sampling edge
  task automatic expect_request(input logic mode, input ninjin_pkg::addr_t base, input int len);
    exp_cyc.push_back(cyc + 3);
    exp_mode.push_back(mode);
    exp_base.push_back(base);
    exp_len.push_back(ninjin_pkg::len_t'(len));
  endtask

  task automatic drop_request();
    void'(exp_cyc.pop_front());
    void'(exp_mode.pop_front());
    void'(exp_base.pop_front());
    void'(exp_len.pop_front());
  endtask

  always @(negedge clk) begin
    if (ddr_req) begin
      if (exp_cyc.size() == 0) begin
        req_errors++;
        $display("[ERROR] %0t: ddr request with no command behind it", $time);
      end else begin
        if (cyc != exp_cyc[0] || ddr_mode !== exp_mode[0] || ddr_base !== exp_base[0]
            || ddr_len !== exp_len[0]) begin
          req_errors++;
          $display("[ERROR] %0t: request cyc %0d mode %0b base %h len %0d, want %0d %0b %h %0d",
                   $time, cyc, ddr_mode, ddr_base, ddr_len,
                   exp_cyc[0], exp_mode[0], exp_base[0], exp_len[0]);
        end
        drop_request();
      end
    end else if (exp_cyc.size() != 0 && exp_cyc[0] < cyc) begin
      req_errors++;
      $display("[ERROR] %0t: no ddr request at cycle %0d", $time, exp_cyc[0]);
      drop_request();
    end
  end

  // drained beats against the reference
  always @(posedge clk) begin
    if (rec_valid) begin
      if (rec_beat !== expected_beat(rec_base, rec_idx)) begin
        data_errors++;
        $display("[ERROR] %0t: beat %0d of base %h is %h, want %h", $time, rec_idx,
                 rec_base, rec_beat, expected_beat(rec_base, rec_idx));
      end
      beats_seen++;
    end
  end

  always @(posedge clk) begin
    if (ddr_we) begin
      boot_img[ddr_addr] = ddr_wdata;
    end
  end

  // ====================
  // stimulus
  // ====================

  task automatic check_boot(input ninjin_pkg::addr_t base, input int nwords);
    int                i;
    ninjin_pkg::word_t want;
    for (i = 0; i < nwords; i++) begin
      mem_addr = base + ninjin_pkg::addr_t'(i);
      @(negedge clk);
      want = boot_img[i / ninjin_pkg::RATE]
               [(i % ninjin_pkg::RATE) * ninjin_pkg::DWIDTH +: ninjin_pkg::DWIDTH];
      if (mem_rdata !== want) begin
        read_errors++;
        $display("[ERROR] %0t: mem_rdata at %h is %h, want %h", $time, mem_addr,
                 mem_rdata, want);
      end
    end
  endtask

  task automatic run_prefetch(input ninjin_pkg::addr_t base, input int tlen);
    int nbeats;
    nbeats    = beats_for(tlen);
    prefetch  = 1'b1;
    base_addr = base;
    total_len = ninjin_pkg::len_t'(tlen);
    expect_request(ninjin_pkg::DDR_READ, base, nbeats);
    @(negedge clk);
    prefetch = 1'b0;
    wait (ddr_busy);
    wait (!ddr_busy);
    @(negedge clk);
    check_boot(base, nbeats * ninjin_pkg::RATE);
  endtask

  // each burst drains before the next words arrive
  task automatic run_stream(input ninjin_pkg::addr_t base, input int n);
    int i;
    int first;
    int start_beats;
    stream_q.delete();
    str_base    = base;
    str_len     = n;
    start_beats = beats_seen;
    total_len   = ninjin_pkg::len_t'(n);
    for (i = 0; i < n; i++) begin
      seed = lcg_next(seed);
      stream_q.push_back(ninjin_pkg::word_t'(seed[31:16]));
      mem_we    = 1'b1;
      mem_addr  = base + ninjin_pkg::addr_t'(i);
      mem_wdata = stream_q[i];
      if (i % ninjin_pkg::BURST_WORDS == ninjin_pkg::BURST_WORDS - 1 || i == n - 1) begin
        first = (i / ninjin_pkg::BURST_WORDS) * ninjin_pkg::BURST_WORDS;
        expect_request(ninjin_pkg::DDR_WRITE, base + ninjin_pkg::addr_t'(first),
                       beats_for(n - first));
        @(negedge clk);
        mem_we = 1'b0;
        wait (beats_seen == start_beats + (i + ninjin_pkg::RATE) / ninjin_pkg::RATE);
        @(negedge clk);
      end else begin
        @(negedge clk);
      end
    end
  endtask

  initial begin
    xrst      = 1'b0;
    prefetch  = 1'b0;
    base_addr = '0;
    total_len = '0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    repeat (10) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);
    if (ddr_req !== 1'b0 || ddr_mode !== 1'b0 || ddr_base !== '0 || ddr_len !== '0) begin
      req_errors++;
      $display("[ERROR] %0t: ddr outputs not zero after reset", $time);
    end
    run_prefetch(16'h0100, 7);
    run_stream(16'h2000, 48);
    run_stream(16'h3005, 37);
    run_stream(16'h4000, 5);
    run_prefetch(16'h0240, 40);
    repeat (4) @(negedge clk);
    if (exp_cyc.size() != 0) begin
      req_errors++;
      $display("[ERROR] %0t: %0d ddr requests never arrived", $time, exp_cyc.size());
    end
    $display("errors: request %0d, drain data %0d, boot read %0d",
             req_errors, data_errors, read_errors);
    if (req_errors + data_errors + read_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // boot reads plus stream words
  initial begin
    int limit;
    limit = (8 + 48 + 37 + 5 + 16) * 4 + 2000;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/ninjin_pkg.sv
src/mem_sp.sv
src/ninjin_ctrl.sv
src/ninjin_ddr_cmd.sv
src/ninjin_prefetch.sv
src/ninjin_pingpong.sv
src/ninjin_ddr_buf.sv
test/ninjin_ddr_model.sv
test/tb_ninjin.sv
